/* eeprom_defs.svh */
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// clk cycles per quarter scl period
`define EE_SCL_QUARTER 4

// 24cxx device type code, upper nibble of the control byte
`define EE_DEV_TYPE 4'b1010

// apb register offsets
`define EE_REG_ADDR   8'h00
`define EE_REG_WDATA  8'h04
`define EE_REG_CMD    8'h08
`define EE_REG_STATUS 8'h0C
`define EE_REG_RDATA  8'h10

`endif

/* eeprom_pkg.sv */
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;  // 2048 bytes
    typedef logic [7:0]  ee_byte_t;

    // bit engine operations
    typedef enum logic [1:0] {
        START,
        STOP,
        WRITE_BIT,
        READ_BIT
    } bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    wbit;   // ignored for start, stop and read
    } bit_req_t;

    typedef struct packed {
        logic done;
        logic rbit;
    } bit_rsp_t;

    typedef struct packed {
        logic     valid;
        logic     wr;    // 1 write, 0 random read
        ee_addr_t addr;
        ee_byte_t data;
    } ee_cmd_t;

    typedef struct packed {
        logic     busy;
        logic     done;
        logic     ack_err;
        ee_byte_t rdata;
    } ee_result_t;

    typedef enum logic [3:0] {
        S_IDLE, S_START, S_CTRL, S_ADDR, S_DATA_WR,
        S_RESTART, S_CTRL_RD, S_DATA_RD, S_STOP, S_FINISH
    } seq_state_e;

endpackage

/* eeprom_apb_regs.sv */
`timescale 1ns/100ps
`include "eeprom_defs.svh"

module eeprom_apb_regs import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output ee_cmd_t     cmd,
    input  ee_result_t  result
);

    ee_addr_t addr_q;
    ee_byte_t wdata_q;
    ee_byte_t rdata_q;
    logic     done_q;
    logic     ack_err_q;
    logic     rd_cmd_q;    // last accepted command was a read
    logic     wr_access;
    logic     cmd_hit;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_access = psel && penable && pwrite;
    assign cmd_hit   = wr_access && (paddr == `EE_REG_CMD) && (pwdata[0] || pwdata[1]);

    // dropped while a frame is running
    assign cmd.valid = cmd_hit && !result.busy;
    assign cmd.wr    = pwdata[0];   // write wins over read
    assign cmd.addr  = addr_q;
    assign cmd.data  = wdata_q;

    always_ff @(posedge CLK)
    begin
        if (wr_access && (paddr == `EE_REG_ADDR))
            addr_q <= pwdata[10:0];
        if (wr_access && (paddr == `EE_REG_WDATA))
            wdata_q <= pwdata[7:0];
        if (result.done && rd_cmd_q)
            rdata_q <= result.rdata;
    end

    // sticky status, cleared by the next accepted command
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            done_q    <= 1'b0;
            ack_err_q <= 1'b0;
            rd_cmd_q  <= 1'b0;
        end
        else if (cmd.valid)
        begin
            done_q    <= 1'b0;
            ack_err_q <= 1'b0;
            rd_cmd_q  <= !cmd.wr;
        end
        else if (result.done)
        begin
            done_q    <= 1'b1;
            ack_err_q <= result.ack_err;
        end
    end

    always_comb
    begin
        prdata = '0;
        if (psel && !pwrite)
        begin
            case (paddr)
                `EE_REG_ADDR:   prdata = {21'b0, addr_q};
                `EE_REG_WDATA:  prdata = {24'b0, wdata_q};
                `EE_REG_STATUS: prdata = {29'b0, ack_err_q, done_q, result.busy};
                `EE_REG_RDATA:  prdata = {24'b0, rdata_q};
                default:        prdata = '0;   // cmd is write only
            endcase
        end
    end

    // sequencer takes the command in the next cycle
    a_cmd_taken: assert property (@(posedge CLK) disable iff (RESET)
        cmd.valid |=> result.busy)
        else $error("command not taken by the sequencer");

endmodule

/* eeprom_frame_seq.sv */
`timescale 1ns/100ps
`include "eeprom_defs.svh"

module eeprom_frame_seq import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  ee_cmd_t    cmd,
    output ee_result_t result,
    output bit_req_t   req,
    output logic       req_valid,
    input  logic       req_ready,
    input  bit_rsp_t   rsp
);

    seq_state_e state_q;
    logic       wr_q;
    ee_addr_t   addr_q;
    ee_byte_t   wdata_q;
    ee_byte_t   sh_q;         // tx and rx shift register
    logic [3:0] bit_cnt_q;    // 0..7 data bits, 8 is the ack slot
    logic       in_flight_q;
    logic       busy_q;
    logic       done_q;
    logic       ack_err_q;
    ee_byte_t   ctrl_wr;
    ee_byte_t   ctrl_rd;

    function automatic bit_req_t mk_req(bit_op_e op, logic wbit);
        bit_req_t r;
        r.op   = op;
        r.wbit = wbit;
        return r;
    endfunction

    assign ctrl_wr = {`EE_DEV_TYPE, addr_q[10:8], 1'b0};
    assign ctrl_rd = {`EE_DEV_TYPE, addr_q[10:8], 1'b1};

    assign result.busy    = busy_q;
    assign result.done    = done_q;
    assign result.ack_err = ack_err_q;
    assign result.rdata   = sh_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state_q     <= S_IDLE;
            req_valid   <= 1'b0;
            req         <= mk_req(STOP, 1'b1);
            in_flight_q <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            ack_err_q   <= 1'b0;
            bit_cnt_q   <= '0;
            wr_q        <= 1'b0;
            addr_q      <= '0;
            wdata_q     <= '0;
            sh_q        <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (req_valid && req_ready)
            begin
                req_valid   <= 1'b0;
                in_flight_q <= 1'b1;
            end

            if (state_q == S_IDLE)
            begin
                if (cmd.valid)
                begin
                    wr_q      <= cmd.wr;
                    addr_q    <= cmd.addr;
                    wdata_q   <= cmd.data;
                    busy_q    <= 1'b1;
                    ack_err_q <= 1'b0;
                    req       <= mk_req(START, 1'b1);
                    req_valid <= 1'b1;
                    state_q   <= S_START;
                end
            end
            else if (state_q == S_FINISH)
            begin
                busy_q  <= 1'b0;
                done_q  <= 1'b1;
                state_q <= S_IDLE;
            end
            else if (in_flight_q && rsp.done)
            begin
                in_flight_q <= 1'b0;
                case (state_q)
                    S_START, S_RESTART:
                    begin
                        sh_q      <= (state_q == S_START) ? ctrl_wr : ctrl_rd;
                        bit_cnt_q <= '0;
                        req       <= mk_req(WRITE_BIT, 1'b1);   // msb of dev type
                        req_valid <= 1'b1;
                        state_q   <= (state_q == S_START) ? S_CTRL : S_CTRL_RD;
                    end
                    S_CTRL, S_ADDR, S_DATA_WR, S_CTRL_RD:
                    begin
                        if (bit_cnt_q < 4'd7)
                        begin
                            sh_q      <= {sh_q[6:0], 1'b0};
                            bit_cnt_q <= bit_cnt_q + 4'd1;
                            req       <= mk_req(WRITE_BIT, sh_q[6]);
                            req_valid <= 1'b1;
                        end
                        else if (bit_cnt_q == 4'd7)
                        begin
                            bit_cnt_q <= 4'd8;
                            req       <= mk_req(READ_BIT, 1'b1);   // slave ack
                            req_valid <= 1'b1;
                        end
                        else if (rsp.rbit)
                        begin
                            // no ack, close the frame
                            ack_err_q <= 1'b1;
                            req       <= mk_req(STOP, 1'b1);
                            req_valid <= 1'b1;
                            state_q   <= S_STOP;
                        end
                        else
                        begin
                            bit_cnt_q <= '0;
                            req_valid <= 1'b1;
                            if (state_q == S_CTRL)
                            begin
                                sh_q    <= addr_q[7:0];
                                req     <= mk_req(WRITE_BIT, addr_q[7]);
                                state_q <= S_ADDR;
                            end
                            else if (state_q == S_ADDR && wr_q)
                            begin
                                sh_q    <= wdata_q;
                                req     <= mk_req(WRITE_BIT, wdata_q[7]);
                                state_q <= S_DATA_WR;
                            end
                            else if (state_q == S_ADDR)
                            begin
                                req     <= mk_req(START, 1'b1);
                                state_q <= S_RESTART;
                            end
                            else if (state_q == S_DATA_WR)
                            begin
                                req     <= mk_req(STOP, 1'b1);
                                state_q <= S_STOP;
                            end
                            else
                            begin
                                req     <= mk_req(READ_BIT, 1'b1);
                                state_q <= S_DATA_RD;
                            end
                        end
                    end
                    S_DATA_RD:
                    begin
                        req_valid <= 1'b1;
                        if (bit_cnt_q < 4'd8)
                        begin
                            sh_q      <= {sh_q[6:0], rsp.rbit};
                            bit_cnt_q <= bit_cnt_q + 4'd1;
                            // last data bit is followed by the master nack
                            req <= (bit_cnt_q == 4'd7) ? mk_req(WRITE_BIT, 1'b1)
                                                       : mk_req(READ_BIT, 1'b1);
                        end
                        else
                        begin
                            req     <= mk_req(STOP, 1'b1);
                            state_q <= S_STOP;
                        end
                    end
                    S_STOP:  state_q <= S_FINISH;
                    default: state_q <= S_IDLE;
                endcase
            end
        end
    end

    a_req_held: assert property (@(posedge CLK) disable iff (RESET)
        req_valid && !req_ready |=> req_valid && $stable(req));

    a_idle_quiet: assert property (@(posedge CLK) disable iff (RESET)
        state_q == S_IDLE |-> !req_valid && !in_flight_q);

endmodule

/* i2c_bit_engine.sv */
`timescale 1ns/100ps
`include "eeprom_defs.svh"

module i2c_bit_engine import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  bit_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output bit_rsp_t rsp,
    output logic     scl_drive_low,
    output logic     sda_drive_low,
    input  logic     sda_in
);

    localparam logic [7:0] QUARTER_LAST = 8'(`EE_SCL_QUARTER - 1);

    bit_op_e    op_q;
    logic       wbit_q;
    logic       active_q;
    logic [1:0] phase_q;
    logic [7:0] qcnt_q;
    logic       rbit_q;
    logic       done_q;
    logic       quarter_end;

    // {scl_low, sda_low} for phase ph of an operation
    function automatic logic [1:0] phase_lines(bit_op_e op, logic [1:0] ph,
                                               logic wbit, logic scl_now);
        logic [1:0] l;
        logic       sda_low;
        sda_low = (op == WRITE_BIT) ? !wbit : 1'b0;   // read releases sda
        case (op)
            START:
                case (ph)
                    2'd0:    l = {scl_now, 1'b0};   // release sda, scl as it was
                    2'd1:    l = 2'b00;
                    2'd2:    l = 2'b01;             // sda falls, scl high
                    default: l = 2'b11;
                endcase
            STOP:
                case (ph)
                    2'd0:    l = 2'b11;
                    2'd1:    l = 2'b01;
                    default: l = 2'b00;             // sda rises, scl high
                endcase
            default:
                l = {(ph == 2'd0 || ph == 2'd3), sda_low};
        endcase
        return l;
    endfunction

    assign req_ready   = !active_q;
    assign quarter_end = active_q && (qcnt_q == QUARTER_LAST);
    assign rsp.done    = done_q;
    assign rsp.rbit    = rbit_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            op_q          <= STOP;
            wbit_q        <= 1'b1;
            active_q      <= 1'b0;
            phase_q       <= '0;
            qcnt_q        <= '0;
            rbit_q        <= 1'b1;
            done_q        <= 1'b0;
            scl_drive_low <= 1'b0;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (req_valid && req_ready)
            begin
                op_q     <= req.op;
                wbit_q   <= req.wbit;
                active_q <= 1'b1;
                phase_q  <= 2'd0;
                qcnt_q   <= '0;
                {scl_drive_low, sda_drive_low} <=
                    phase_lines(req.op, 2'd0, req.wbit, scl_drive_low);
            end
            else if (quarter_end)
            begin
                qcnt_q <= '0;
                if (phase_q == 2'd3)
                begin
                    active_q <= 1'b0;   // lines hold their last phase
                    done_q   <= 1'b1;
                end
                else
                begin
                    phase_q <= phase_q + 2'd1;
                    {scl_drive_low, sda_drive_low} <=
                        phase_lines(op_q, phase_q + 2'd1, wbit_q, scl_drive_low);
                    if (phase_q == 2'd1)
                        rbit_q <= sda_in;   // middle of scl high
                end
            end
            else if (active_q)
                qcnt_q <= qcnt_q + 8'd1;
        end
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (!scl_drive_low && $past(!scl_drive_low) && !(op_q inside {START, STOP}))
        |-> $stable(sda_drive_low));

endmodule

/* eeprom_ctrl_top.sv */
`timescale 1ns/100ps

module eeprom_ctrl_top import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl_drive_low,
    output logic        sda_drive_low,
    input  logic        scl_in,        // reserved for clock stretching
    input  logic        sda_in
);

    ee_cmd_t    cmd;
    ee_result_t result;
    bit_req_t   req;
    logic       req_valid;
    logic       req_ready;
    bit_rsp_t   rsp;

    eeprom_apb_regs regs_i (
        .CLK, .RESET,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .cmd, .result
    );

    eeprom_frame_seq seq_i (
        .CLK, .RESET,
        .cmd, .result,
        .req, .req_valid, .req_ready, .rsp
    );

    i2c_bit_engine bit_i (
        .CLK, .RESET,
        .req, .req_valid, .req_ready, .rsp,
        .scl_drive_low, .sda_drive_low, .sda_in
    );

endmodule

/* tb_eeprom_model.sv */
`timescale 1ns/100ps
`include "eeprom_defs.svh"

module tb_eeprom_model #(
    parameter logic [7:0] FILL_SEED = 8'h3c
)
(
    input  wire  scl,
    input  wire  sda,
    input  logic nack_all,        // refuse every control byte
    output logic sda_drive_low,
    output int   start_count
);

    typedef enum {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA, M_IGNORE} mode_e;

    logic [7:0]  mem [0:2047];
    mode_e       mode;
    int          bit_cnt;        // rising scl edges seen in this byte slot
    logic [7:0]  shreg;
    logic [2:0]  page;           // upper address bits from the control byte
    logic        rw;
    logic        acked;
    logic [10:0] ptr;
    logic        scl_q;
    logic        sda_q;

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]} ^ FILL_SEED;
    endfunction

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = fill_byte(11'(a));
        mode          = M_IDLE;
        bit_cnt       = 0;
        shreg         = 8'h00;
        page          = 3'b000;
        rw            = 1'b0;
        acked         = 1'b0;
        ptr           = 11'h000;
        sda_drive_low = 1'b0;
        start_count   = 0;
        scl_q         = 1'b1;
        sda_q         = 1'b1;
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            start_count++;   // start or repeated start
            mode    = M_CTRL;
            bit_cnt = 0;
        end
        else if (scl && scl_q && !sda_q && sda)
            mode = M_IDLE;   // stop
        else if (scl && !scl_q && mode != M_IDLE && mode != M_IGNORE)
        begin
            if (bit_cnt < 8 && mode != M_RDATA)
                shreg = {shreg[6:0], sda};
            else if (bit_cnt == 8)
                acked = !sda;   // ack clock
            bit_cnt++;
        end
        else if (!scl && scl_q && mode != M_IDLE && mode != M_IGNORE)
        begin
            if (bit_cnt == 8)
            begin
                sda_drive_low = 1'b0;
                if (mode == M_CTRL)
                begin
                    {page, rw}    = shreg[3:0];
                    sda_drive_low = (shreg[7:4] == `EE_DEV_TYPE) && !nack_all;
                end
                else if (mode == M_ADDR)
                begin
                    ptr           = {page, shreg};
                    sda_drive_low = 1'b1;
                end
                else if (mode == M_WDATA)
                begin
                    mem[ptr]      = shreg;
                    sda_drive_low = 1'b1;
                end
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt       = 0;
                sda_drive_low = 1'b0;
                if (mode == M_CTRL && acked && rw)
                begin
                    mode          = M_RDATA;
                    shreg         = mem[ptr];
                    sda_drive_low = !shreg[7];
                end
                else if (mode == M_CTRL && acked)
                    mode = M_ADDR;
                else if (mode == M_ADDR)
                    mode = M_WDATA;
                else
                    mode = M_IGNORE;   // one data byte per frame
            end
            else if (mode == M_RDATA && bit_cnt > 0)
                sda_drive_low = !shreg[7 - bit_cnt];
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* tb_eeprom_ctrl.sv */
`timescale 1ns/100ps
`include "eeprom_defs.svh"

module tb_eeprom_ctrl;

    localparam int OP_CYCLES    = 4 * `EE_SCL_QUARTER + 4;   // bit op plus handshake
    localparam int FRAME_CYCLES = 48 * OP_CYCLES;
    localparam int NUM_FRAMES   = 70;
    localparam int WATCHDOG_NS  = 2 * FRAME_CYCLES * NUM_FRAMES * 10 + 20000;
    localparam int RAND_PAIRS   = 20;
    localparam logic [7:0] FILL_SEED = 8'h3c;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl_drive_low;
    logic        sda_drive_low;
    logic        model_sda_low;
    logic        nack_all;
    int          start_count;
    wire         scl;
    wire         sda;
    logic [7:0]  ref_mem [0:2047];
    int          errors;
    int          checks;
    int          tests;

    assign scl = !scl_drive_low;
    assign sda = !sda_drive_low && !model_sda_low;   // wired and, pulled up

    eeprom_ctrl_top dut_i (
        .CLK, .RESET,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .scl_drive_low, .sda_drive_low,
        .scl_in(scl), .sda_in(sda)
    );

    tb_eeprom_model #(.FILL_SEED(FILL_SEED)) model_i (
        .scl, .sda, .nack_all,
        .sda_drive_low(model_sda_low),
        .start_count
    );

    always #5 CLK = !CLK;

    function automatic logic [7:0] expected_fill(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]} ^ FILL_SEED;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errs_before);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge CLK);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge CLK);
        #1;
        penable = 1'b1;
        @(posedge CLK);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge CLK);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge CLK);
        #1;
        penable = 1'b1;
        @(negedge CLK);
        data = prdata;   // mid access phase
        check_eq("apb_read pready", 32'h1, {31'b0, pready});
        check_eq("apb_read pslverr", 32'h0, {31'b0, pslverr});
        @(posedge CLK);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'h1;
        while (st[0])
            apb_read(`EE_REG_STATUS, st);
    endtask

    task automatic store_byte(input logic [10:0] addr, input logic [7:0] data);
        apb_write(`EE_REG_ADDR, {21'b0, addr});
        apb_write(`EE_REG_WDATA, {24'b0, data});
        apb_write(`EE_REG_CMD, 32'h1);
        wait_idle();
    endtask

    task automatic fetch_byte(input logic [10:0] addr, output logic [7:0] data);
        logic [31:0] rd;
        apb_write(`EE_REG_ADDR, {21'b0, addr});
        apb_write(`EE_REG_CMD, 32'h2);
        wait_idle();
        apb_read(`EE_REG_RDATA, rd);
        data = rd[7:0];
    endtask

    task automatic reset_values();
        logic [31:0] rd;
        int          e0;
        e0 = errors;
        apb_read(`EE_REG_STATUS, rd);
        check_eq("reset_values status", 32'h0, rd);
        check_eq("reset_values scl", 32'h1, {31'b0, scl});
        check_eq("reset_values sda", 32'h1, {31'b0, sda});
        apb_write(`EE_REG_ADDR, 32'h5a3);
        apb_write(`EE_REG_WDATA, 32'hc6);
        apb_read(`EE_REG_ADDR, rd);
        check_eq("reset_values addr", 32'h5a3, rd);
        apb_read(`EE_REG_WDATA, rd);
        check_eq("reset_values wdata", 32'hc6, rd);
        report_test("reset_values", e0);
    endtask

    task automatic write_then_read();
        logic [31:0] rd;
        logic [7:0]  d;
        int          e0;
        e0 = errors;
        store_byte(11'h123, 8'ha7);
        ref_mem[11'h123] = 8'ha7;
        fetch_byte(11'h123, d);
        check_eq("write_then_read data", {24'b0, ref_mem[11'h123]}, {24'b0, d});
        apb_read(`EE_REG_STATUS, rd);
        check_eq("write_then_read status", 32'h2, rd);   // done, no ack error
        report_test("write_then_read", e0);
    endtask

    task automatic preload_read();
        logic [10:0] a;
        logic [7:0]  d;
        int          e0;
        e0 = errors;
        for (int k = 0; k < 4; k++)
        begin
            a = 11'(k * 600 + 7);
            fetch_byte(a, d);
            check_eq("preload_read data", {24'b0, ref_mem[a]}, {24'b0, d});
        end
        report_test("preload_read", e0);
    endtask

    task automatic refused_ack();
        logic [31:0] rd;
        logic [7:0]  d;
        int          e0;
        e0 = errors;
        nack_all = 1'b1;
        store_byte(11'h456, 8'h3e);   // control byte refused, memory untouched
        apb_read(`EE_REG_STATUS, rd);
        check_eq("refused_ack write status", 32'h6, rd);
        apb_write(`EE_REG_CMD, 32'h2);
        wait_idle();
        apb_read(`EE_REG_STATUS, rd);
        check_eq("refused_ack read status", 32'h6, rd);
        nack_all = 1'b0;
        fetch_byte(11'h456, d);
        check_eq("refused_ack data", {24'b0, ref_mem[11'h456]}, {24'b0, d});
        apb_read(`EE_REG_STATUS, rd);
        check_eq("refused_ack recovered status", 32'h2, rd);
        report_test("refused_ack", e0);
    endtask

    task automatic cmd_while_busy();
        logic [31:0] rd;
        logic [7:0]  d;
        int          s0;
        int          e0;
        e0 = errors;
        s0 = start_count;
        apb_write(`EE_REG_ADDR, 32'h789);
        apb_write(`EE_REG_WDATA, 32'h11);
        apb_write(`EE_REG_CMD, 32'h1);
        apb_write(`EE_REG_WDATA, 32'h22);
        apb_write(`EE_REG_CMD, 32'h1);   // lands mid frame
        apb_read(`EE_REG_STATUS, rd);
        check_eq("cmd_while_busy busy", 32'h1, {31'b0, rd[0]});
        wait_idle();
        check_eq("cmd_while_busy frames", 32'(s0 + 1), 32'(start_count));
        ref_mem[11'h789] = 8'h11;
        fetch_byte(11'h789, d);
        check_eq("cmd_while_busy data", {24'b0, ref_mem[11'h789]}, {24'b0, d});
        report_test("cmd_while_busy", e0);
    endtask

    task automatic random_sweep();
        logic [10:0] a;
        logic [7:0]  lo;
        logic [7:0]  d;
        int          e0;
        e0 = errors;
        lo = 8'($urandom);
        // same low byte, all eight pages
        for (int k = 0; k < 8; k++)
        begin
            a = {3'(k), lo};
            ref_mem[a] = 8'($urandom);
            store_byte(a, ref_mem[a]);
        end
        for (int k = 0; k < 8; k++)
        begin
            a = {3'(k), lo};
            fetch_byte(a, d);
            check_eq("random_sweep page", {24'b0, ref_mem[a]}, {24'b0, d});
        end
        for (int n = 0; n < RAND_PAIRS; n++)
        begin
            a = 11'($urandom);
            ref_mem[a] = 8'($urandom);
            store_byte(a, ref_mem[a]);
            fetch_byte(a, d);
            check_eq("random_sweep data", {24'b0, ref_mem[a]}, {24'b0, d});
        end
        report_test("random_sweep", e0);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed, a frame never ended");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        errors   = 0;
        checks   = 0;
        tests    = 0;
        RESET    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 8'h00;
        pwdata   = 32'h0;
        nack_all = 1'b0;
        void'($urandom(32'h75b7_10f9));
        for (int a = 0; a < 2048; a++)
            ref_mem[a] = expected_fill(11'(a));
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;

        reset_values();
        write_then_read();
        preload_read();
        refused_ack();
        cmd_while_busy();
        random_sweep();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
eeprom_pkg.sv
eeprom_apb_regs.sv
eeprom_frame_seq.sv
i2c_bit_engine.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the eeprom controller testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 -f project.f \
    --top-module tb_eeprom_ctrl --Mdir obj_dir -o tb_eeprom_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_eeprom_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
